//--- project.f
logic/soc_pkg.sv
logic/clock_slower.sv
logic/ps2_decoder.sv
logic/unified_memory.sv
logic/bus_controller.sv
logic/interrupt_controller.sv
logic/cpu_on_board.sv
testbench/cpu_on_board_checker.sv
testbench/tb_cpu_on_board.sv

//--- testbench/tb_cpu_on_board.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_on_board;
    import soc_pkg::*;

    localparam int tick_divide  = 16;
    localparam int clk_period   = 10;
    // PS/2 half bit in system clocks, 200 ns
    localparam int ps2_half     = 20;
    localparam int frame_count  = 14;
    localparam int bus_op_count = 220;
    // Frame is 11 bits plus idle, bus op a few clocks, twice for margin
    localparam int watchdog_ns  = 2 * clk_period *
        (frame_count * 24 * ps2_half + bus_op_count * 4 + 16 * tick_divide);

    logic                  CLOCK_50;
    logic                  KEY0;
    logic                  PS2_CLK;
    logic                  PS2_DAT;
    logic [addr_width-1:0] pc;
    logic [word_width-1:0] instruction;
    logic [addr_width-1:0] bus_address;
    logic [data_width-1:0] bus_write_data;
    logic                  bus_write_enable;
    logic                  bus_read_enable;
    logic [data_width-1:0] bus_read_data;
    logic                  interrupt_ack;
    logic [3:0]            interrupt_vector;
    logic                  cpu_tick;
    logic [word_width-1:0] uart_write_data;
    logic                  uart_write_strobe;
    logic [7:0]            LEDG;
    logic                  LEDR0;
    logic [5:0]            LEDR_PC;

    // Reference state
    logic [word_width-1:0] ref_mem [0:mem_words-1];
    logic [7:0]            model_ascii;
    logic                  model_break;
    logic                  model_irq;
    logic [31:0]           lcg_state;
    logic [63:0]           written_q [$];
    // Pending comparisons
    logic [63:0]           expected_q [$];
    logic [63:0]           actual_q [$];
    string                 label_q [$];
    time                   time_q [$];
    int                    error_count;
    int                    check_count;
    int                    test_errors;
    int                    test_checks;
    int                    strobe_count;
    int                    strobe_before;
    logic [word_width-1:0] strobe_data;
    // Scratch for the test sequence
    logic [63:0]           addr;
    logic [63:0]           data;
    int                    gap;
    int                    total_errors;
    logic [7:0]            make_codes [7] = '{8'h1C, 8'h32, 8'h45, 8'h16, 8'h29, 8'h5A, 8'h05};

    always #(clk_period / 2) CLOCK_50 = ~CLOCK_50;

    cpu_on_board #(
        .tick_divide (tick_divide)
    ) i_dut (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .PS2_CLK           (PS2_CLK),
        .PS2_DAT           (PS2_DAT),
        .pc                (pc),
        .instruction       (instruction),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable),
        .bus_read_enable   (bus_read_enable),
        .bus_read_data     (bus_read_data),
        .interrupt_ack     (interrupt_ack),
        .interrupt_vector  (interrupt_vector),
        .cpu_tick          (cpu_tick),
        .uart_write_data   (uart_write_data),
        .uart_write_strobe (uart_write_strobe),
        .LEDG              (LEDG),
        .LEDR0             (LEDR0),
        .LEDR_PC           (LEDR_PC)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 ROM, 1 RAM, 2 keyboard, 3 UART, 4 unmapped
    function automatic int region_of(input logic [63:0] a);
        if (a >= rom_base && a < rom_base + rom_size) return 0;
        if (a >= ram_base && a < ram_base + ram_size) return 1;
        if (a == key_base) return 2;
        if (a == art_base) return 3;
        return 4;
    endfunction

    // Set-2 letters and digits, plus space and enter
    function automatic logic [7:0] ascii_of_scan(input logic [7:0] code);
        logic [7:0] letters [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
            8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15,
            8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
        logic [7:0] digits [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
            8'h3D, 8'h3E, 8'h46};
        ascii_of_scan = 8'h00;
        for (int i = 0; i < 26; i++) begin
            if (code == letters[i]) ascii_of_scan = 8'h61 + i;
        end
        for (int i = 0; i < 10; i++) begin
            if (code == digits[i]) ascii_of_scan = 8'h30 + i;
        end
        if (code == 8'h29) ascii_of_scan = 8'h20;
        if (code == 8'h5A) ascii_of_scan = 8'h0D;
    endfunction

    function automatic logic [31:0] byte_swap(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            byte_swap[8*i +: 8] = w[8*(3-i) +: 8];
        end
    endfunction

    // Read result by the address map
    function automatic logic [63:0] expected_read(input logic [63:0] a);
        case (region_of(a))
            0, 1: return {32'h0, ref_mem[a[mem_index_width+1:2]]};
            2: return {56'h0, model_ascii};
            default: return 64'h0;
        endcase
    endfunction

    task automatic expect_value(input string what, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        label_q.push_back(what);
        expected_q.push_back(exp_v);
        actual_q.push_back(act_v);
        time_q.push_back($time);
    endtask

    // Entries queued mid-cycle are compared on the next rising edge
    always @(posedge CLOCK_50) begin : compare
        string       what;
        logic [63:0] exp_v;
        logic [63:0] act_v;
        time         when;
        while (actual_q.size() > 0) begin
            what  = label_q.pop_front();
            exp_v = expected_q.pop_front();
            act_v = actual_q.pop_front();
            when  = time_q.pop_front();
            check_count++;
            assert (act_v === exp_v)
            else begin
                error_count++;
                $display("[FAIL] %0d ns: %s expected %h got %h", when, what, exp_v, act_v);
            end
        end
    end

    // Strobe as seen by a synchronous consumer
    always @(posedge CLOCK_50) begin
        if (uart_write_strobe) begin
            strobe_count++;
            strobe_data = uart_write_data;
        end
    end

    // All bus tasks start and end on a falling edge
    task automatic write_bus(input logic [63:0] a, input logic [63:0] d);
        bus_address      = a;
        bus_write_data   = d;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        if (region_of(a) == 1) ref_mem[a[mem_index_width+1:2]] = d[31:0];
    endtask

    // Result shows one clock after the sampling edge
    task automatic read_and_check(input string what, input logic [63:0] a);
        bus_address     = a;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        @(negedge CLOCK_50);
        expect_value(what, expected_read(a), bus_read_data);
    endtask

    // Start, 8 data LSB first, odd parity, stop
    task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            PS2_DAT = bits[i];
            repeat (ps2_half) @(negedge CLOCK_50);
            PS2_CLK = 1'b0;
            repeat (ps2_half) @(negedge CLOCK_50);
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
        // Idle gap longer than the decode latency
        repeat (ps2_half) @(negedge CLOCK_50);
        if (!bad_parity) begin
            if (code == ps2_break_code) begin
                model_break = 1'b1;
            end else if (model_break) begin
                model_break = 1'b0;
            end else begin
                model_ascii = ascii_of_scan(code);
                if (model_ascii != 8'h00) model_irq = 1'b1;
            end
        end
    endtask

    task automatic acknowledge_irq();
        interrupt_ack = 1'b1;
        @(negedge CLOCK_50);
        interrupt_ack = 1'b0;
        model_irq     = 1'b0;
    endtask

    // Let the compare process drain, then one summary line
    task automatic finish_test(input string name);
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        $display("%-16s %0d checks, %0d errors", name, check_count - test_checks,
                 error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    initial begin
        CLOCK_50         = 1'b0;
        KEY0             = 1'b0;
        PS2_CLK          = 1'b1;
        PS2_DAT          = 1'b1;
        pc               = '0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        interrupt_ack    = 1'b0;
        model_ascii      = 8'h00;
        model_break      = 1'b0;
        model_irq        = 1'b0;
        lcg_state        = 32'hf8ca;
        error_count      = 0;
        check_count      = 0;
        test_errors      = 0;
        test_checks      = 0;
        strobe_count     = 0;
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = '0;
        end
        repeat (8) @(negedge CLOCK_50);
        KEY0 = 1'b1;

        // Reset state and step enable period
        expect_value("strobe after reset", 64'd0, uart_write_strobe);
        expect_value("vector after reset", 64'd0, interrupt_vector);
        expect_value("LEDR0 after reset", 64'd0, LEDR0);
        expect_value("read data after reset", 64'd0, bus_read_data);
        for (int k = 0; k < 4; k++) begin
            gap = 0;
            if (k > 0) begin
                @(negedge CLOCK_50);
                gap = 1;
            end
            while (!cpu_tick && gap < 4 * tick_divide) begin
                @(negedge CLOCK_50);
                gap++;
            end
            expect_value("cpu_tick spacing", tick_divide, gap);
        end
        finish_test("reset state");

        // Random RAM traffic, then ROM and unmapped writes
        for (int i = 0; i < 64; i++) begin
            lcg_state = lcg_next(lcg_state);
            addr      = ram_base + {lcg_state[30:20], 2'b00};
            lcg_state = lcg_next(lcg_state);
            data[63:32] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            data[31:0] = lcg_state;
            write_bus(addr, data);
            written_q.push_back(addr);
            read_and_check("ram read", addr);
        end
        // Nonzero word where 0x5000 lands inside the array
        write_bus(ram_base, 64'h9999_AAAA_BBBB_CCCC);
        write_bus(rom_base + 64'h40, 64'hDEAD_BEEF_CAFE_F00D);
        write_bus(64'h5000, 64'h1111_2222_3333_4444);
        write_bus(64'h3000, 64'h5555_6666_7777_8888);
        read_and_check("rom read", rom_base + 64'h40);
        read_and_check("unmapped read", 64'h5000);
        read_and_check("unmapped read", 64'h3000);
        // 0x5000 folds onto the first RAM word inside the array
        read_and_check("ram alias", ram_base);
        finish_test("bus memory");

        // Fetch port
        for (int i = 0; i < 8; i++) begin
            pc = written_q[i * 8];
            @(negedge CLOCK_50);
            expect_value("instruction", byte_swap(ref_mem[pc[mem_index_width+1:2]]), instruction);
            expect_value("LEDR_PC", pc[7:2], LEDR_PC);
        end
        pc = rom_base + 64'h10;
        @(negedge CLOCK_50);
        expect_value("rom instruction", 64'd0, instruction);
        finish_test("fetch");

        // Make codes, break sequence, bad parity
        foreach (make_codes[i]) begin
            send_ps2_frame(make_codes[i], 1'b0);
            read_and_check("key read", key_base);
        end
        send_ps2_frame(8'h1C, 1'b0);
        read_and_check("key read", key_base);
        send_ps2_frame(ps2_break_code, 1'b0);
        send_ps2_frame(8'h33, 1'b0);
        read_and_check("key after break", key_base);
        send_ps2_frame(8'h4D, 1'b1);
        read_and_check("key after bad parity", key_base);
        send_ps2_frame(8'h1A, 1'b0);
        read_and_check("key after recovery", key_base);
        expect_value("LEDG", model_ascii, LEDG);
        finish_test("keyboard");

        // Interrupt raise, hold, acknowledge
        acknowledge_irq();
        expect_value("vector cleared", 64'd0, interrupt_vector);
        send_ps2_frame(8'h24, 1'b0);
        expect_value("vector on key", model_irq ? irq_keyboard : 4'd0, interrupt_vector);
        expect_value("LEDR0 on key", model_irq, LEDR0);
        repeat (5) @(negedge CLOCK_50);
        interrupt_ack = 1'b1;
        expect_value("vector held", model_irq ? irq_keyboard : 4'd0, interrupt_vector);
        @(negedge CLOCK_50);
        interrupt_ack = 1'b0;
        model_irq     = 1'b0;
        expect_value("vector after ack", 64'd0, interrupt_vector);
        expect_value("LEDR0 after ack", 64'd0, LEDR0);
        send_ps2_frame(8'h05, 1'b0);
        expect_value("vector untranslated", model_irq ? irq_keyboard : 4'd0, interrupt_vector);
        finish_test("interrupt");

        // UART strobe with write enable held
        strobe_before    = strobe_count;
        lcg_state        = lcg_next(lcg_state);
        data             = {32'hA5A5_5A5A, lcg_state};
        bus_address      = art_base;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        repeat (3) @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        @(negedge CLOCK_50);
        expect_value("strobe count", 64'd1, strobe_count - strobe_before);
        expect_value("strobe data", data[31:0], strobe_data);
        strobe_before = strobe_count;
        write_bus(written_q[0], 64'h0123_4567_89AB_CDEF);
        write_bus(key_base, 64'h0000_0000_0000_0041);
        write_bus(art_base + 64'h8, 64'h0000_0000_0000_0042);
        @(negedge CLOCK_50);
        expect_value("stray strobes", 64'd0, strobe_count - strobe_before);
        finish_test("uart");

        total_errors = error_count + i_dut.i_bus_controller.i_checker.failure_count;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures", check_count,
                 error_count, i_dut.i_bus_controller.i_checker.failure_count);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cpu_on_board_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_on_board_checker (
    input wire                            CLOCK_50,
    input wire                            KEY0,
    input wire [soc_pkg::addr_width-1:0]  bus_address,
    input wire [soc_pkg::data_width-1:0]  bus_read_data,
    input wire                            mem_write,
    input wire                            uart_write_strobe
);
    import soc_pkg::*;

    // Assertion failures so far
    int unsigned failure_count = 0;

    logic in_ram;

    // RAM window of the address map
    assign in_ram = (bus_address >= ram_base) && (bus_address < ram_base + ram_size);

    // Strobe is a one-clock pulse per write burst
    strobe_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write_strobe |=> !uart_write_strobe)
    else begin
        failure_count++;
        $error("uart_write_strobe high on two consecutive clocks");
    end

    // Only the low word ever carries data
    upper_zero: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_data[data_width-1:word_width] == '0)
    else begin
        failure_count++;
        $error("upper half of bus_read_data is not zero");
    end

    // Memory writes start only inside RAM
    write_in_ram: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(mem_write) |-> in_ram)
    else begin
        failure_count++;
        $error("mem_write rose for an address outside RAM");
    end

endmodule

bind bus_controller cpu_on_board_checker i_checker (
    .CLOCK_50          (CLOCK_50),
    .KEY0              (KEY0),
    .bus_address       (bus_address),
    .bus_read_data     (bus_read_data),
    .mem_write         (mem_write),
    .uart_write_strobe (uart_write_strobe)
);

`default_nettype wire

//--- logic/cpu_on_board.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_on_board #(
    parameter int tick_divide = soc_pkg::tick_divide_default
) (
    input  wire                             CLOCK_50,
    input  wire                             KEY0,
    input  wire                             PS2_CLK,
    input  wire                             PS2_DAT,
    input  wire  [soc_pkg::addr_width-1:0]  pc,
    output logic [soc_pkg::word_width-1:0]  instruction,
    input  wire  [soc_pkg::addr_width-1:0]  bus_address,
    input  wire  [soc_pkg::data_width-1:0]  bus_write_data,
    input  wire                             bus_write_enable,
    input  wire                             bus_read_enable,
    output logic [soc_pkg::data_width-1:0]  bus_read_data,
    input  wire                             interrupt_ack,
    output logic [3:0]                      interrupt_vector,
    output logic                            cpu_tick,
    output logic [soc_pkg::word_width-1:0]  uart_write_data,
    output logic                            uart_write_strobe,
    output logic [7:0]                      LEDG,
    output logic                            LEDR0,
    output logic [5:0]                      LEDR_PC
);
    import soc_pkg::*;

    // Bus controller to memory port B
    logic [addr_width-1:0] mem_address;
    logic                  mem_write;
    logic [word_width-1:0] mem_write_data;
    logic [word_width-1:0] mem_read_data;
    // Keyboard
    logic [7:0]            ascii_code;
    logic                  key_pressed;

    // CPU step enable
    clock_slower #(
        .tick_divide (tick_divide)
    ) i_clock_slower (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .cpu_tick (cpu_tick)
    );

    // Scan code and release pulse stay internal
    ps2_decoder i_ps2_decoder (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .ps2_clk      (PS2_CLK),
        .ps2_dat      (PS2_DAT),
        .scan_code    (),
        .ascii_code   (ascii_code),
        .key_pressed  (key_pressed),
        .key_released ()
    );

    unified_memory i_unified_memory (
        .CLOCK_50       (CLOCK_50),
        .pc             (pc),
        .instruction    (instruction),
        .mem_address    (mem_address),
        .mem_write      (mem_write),
        .mem_write_data (mem_write_data),
        .mem_read_data  (mem_read_data)
    );

    bus_controller i_bus_controller (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable),
        .bus_read_enable   (bus_read_enable),
        .bus_read_data     (bus_read_data),
        .mem_address       (mem_address),
        .mem_write         (mem_write),
        .mem_write_data    (mem_write_data),
        .mem_read_data     (mem_read_data),
        .ascii_code        (ascii_code),
        .uart_write_data   (uart_write_data),
        .uart_write_strobe (uart_write_strobe)
    );

    interrupt_controller i_interrupt_controller (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_pressed      (key_pressed),
        .ascii_code       (ascii_code),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector)
    );

    // Board LEDs, last key, pending irq, fetch word index
    assign LEDG    = ascii_code;
    assign LEDR0   = |interrupt_vector;
    assign LEDR_PC = pc[7:2];

endmodule

`default_nettype wire

//--- logic/interrupt_controller.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller (
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  wire        key_pressed,
    input  wire  [7:0] ascii_code,
    input  wire        interrupt_ack,
    output logic [3:0] interrupt_vector
);
    import soc_pkg::*;

    // Vector pending until the core acknowledges
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= 4'd0;
        end else if (interrupt_ack && interrupt_vector != 4'd0) begin
            // Ack beats a simultaneous key press
            interrupt_vector <= 4'd0;
        end else if (key_pressed && ascii_code != 8'd0) begin
            // Untranslated keys raise nothing
            interrupt_vector <= irq_keyboard;
        end
    end

endmodule

`default_nettype wire

//--- logic/bus_controller.sv
`timescale 1ns/1ps
`default_nettype none

module bus_controller (
    input  wire                             CLOCK_50,
    input  wire                             KEY0,
    input  wire  [soc_pkg::addr_width-1:0]  bus_address,
    input  wire  [soc_pkg::data_width-1:0]  bus_write_data,
    input  wire                             bus_write_enable,
    input  wire                             bus_read_enable,
    output logic [soc_pkg::data_width-1:0]  bus_read_data,
    output logic [soc_pkg::addr_width-1:0]  mem_address,
    output logic                            mem_write,
    output logic [soc_pkg::word_width-1:0]  mem_write_data,
    input  wire  [soc_pkg::word_width-1:0]  mem_read_data,
    input  wire  [7:0]                      ascii_code,
    output logic [soc_pkg::word_width-1:0]  uart_write_data,
    output logic                            uart_write_strobe
);
    import soc_pkg::*;

    // Region decode
    logic rom_sel;
    logic ram_sel;
    logic key_sel;
    logic art_sel;
    // Read pipeline state
    logic read_pending;
    logic rd_mem_sel;
    logic rd_key_sel;
    // UART write level and its delayed copy
    logic uart_trigger;
    logic uart_trigger_dly;

    assign rom_sel = (bus_address >= rom_base) && (bus_address < rom_base + rom_size);
    assign ram_sel = (bus_address >= ram_base) && (bus_address < ram_base + ram_size);
    assign key_sel = (bus_address == key_base);
    assign art_sel = (bus_address == art_base);

    // Memory sees every address, only RAM may be written
    assign mem_address    = bus_address;
    assign mem_write      = bus_write_enable && ram_sel;
    assign mem_write_data = bus_write_data[word_width-1:0];

    // First clock registers region with memory read, second selects result
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_pending  <= 1'b0;
            rd_mem_sel    <= 1'b0;
            rd_key_sel    <= 1'b0;
            bus_read_data <= '0;
        end else begin
            read_pending <= bus_read_enable;
            if (bus_read_enable) begin
                rd_mem_sel <= rom_sel || ram_sel;
                rd_key_sel <= key_sel;
            end
            if (read_pending) begin
                if (rd_mem_sel) begin
                    bus_read_data <= {{(data_width - word_width){1'b0}}, mem_read_data};
                end else if (rd_key_sel) begin
                    bus_read_data <= {{(data_width - 8){1'b0}}, ascii_code};
                end else begin
                    // Unmapped reads as zero
                    bus_read_data <= '0;
                end
            end
        end
    end

    // One strobe per write burst to the UART register
    assign uart_trigger = bus_write_enable && art_sel;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_trigger_dly <= 1'b0;
        end else begin
            uart_trigger_dly <= uart_trigger;
        end
    end

    assign uart_write_strobe = uart_trigger && !uart_trigger_dly;
    assign uart_write_data   = bus_write_data[word_width-1:0];

endmodule

`default_nettype wire

//--- logic/unified_memory.sv
`timescale 1ns/1ps
`default_nettype none

module unified_memory (
    input  wire                              CLOCK_50,
    input  wire  [soc_pkg::addr_width-1:0]   pc,
    output logic [soc_pkg::word_width-1:0]   instruction,
    input  wire  [soc_pkg::addr_width-1:0]   mem_address,
    input  wire                              mem_write,
    input  wire  [soc_pkg::word_width-1:0]   mem_write_data,
    output logic [soc_pkg::word_width-1:0]   mem_read_data
);
    import soc_pkg::*;

    // Single array holds ROM and RAM words
    logic [word_width-1:0] mem [0:mem_words-1];

    // Word indices from byte addresses
    logic [mem_index_width-1:0] fetch_index;
    logic [mem_index_width-1:0] bus_index;
    // Raw fetched word before swap
    logic [word_width-1:0]      fetch_word;

    assign fetch_index = pc[mem_index_width+1:2];
    assign bus_index   = mem_address[mem_index_width+1:2];

    // Start from a cleared memory
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // Port A, instruction fetch, read only
    always @(posedge CLOCK_50) begin
        fetch_word <= mem[fetch_index];
    end

    // Memory is stored big endian, core wants little endian
    assign instruction = {fetch_word[7:0], fetch_word[15:8],
                          fetch_word[23:16], fetch_word[31:24]};

    // Port B, bus side
    always @(posedge CLOCK_50) begin
        if (mem_write) begin
            mem[bus_index] <= mem_write_data;
        end
        // Old data on a same-address write
        mem_read_data <= mem[bus_index];
    end

endmodule

`default_nettype wire

//--- logic/ps2_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_decoder (
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  wire        ps2_clk,
    input  wire        ps2_dat,
    output logic [7:0] scan_code,
    output logic [7:0] ascii_code,
    output logic       key_pressed,
    output logic       key_released
);
    import soc_pkg::*;

    // Synchronizer stages, bit 1 is the safe copy
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;
    // 0 idle, 1..9 data and parity, 10 stop
    logic [3:0] bit_count;
    // Data bits then parity, filled LSB first
    logic [8:0] frame_shift;
    logic       frame_valid;
    logic       break_flag;

    // Set-2 make codes to ASCII, zero when untranslated
    function automatic logic [7:0] to_ascii(input logic [7:0] code);
        case (code)
            8'h1C: to_ascii = "a";
            8'h32: to_ascii = "b";
            8'h21: to_ascii = "c";
            8'h23: to_ascii = "d";
            8'h24: to_ascii = "e";
            8'h2B: to_ascii = "f";
            8'h34: to_ascii = "g";
            8'h33: to_ascii = "h";
            8'h43: to_ascii = "i";
            8'h3B: to_ascii = "j";
            8'h42: to_ascii = "k";
            8'h4B: to_ascii = "l";
            8'h3A: to_ascii = "m";
            8'h31: to_ascii = "n";
            8'h44: to_ascii = "o";
            8'h4D: to_ascii = "p";
            8'h15: to_ascii = "q";
            8'h2D: to_ascii = "r";
            8'h1B: to_ascii = "s";
            8'h2C: to_ascii = "t";
            8'h3C: to_ascii = "u";
            8'h2A: to_ascii = "v";
            8'h1D: to_ascii = "w";
            8'h22: to_ascii = "x";
            8'h35: to_ascii = "y";
            8'h1A: to_ascii = "z";
            8'h45: to_ascii = "0";
            8'h16: to_ascii = "1";
            8'h1E: to_ascii = "2";
            8'h26: to_ascii = "3";
            8'h25: to_ascii = "4";
            8'h2E: to_ascii = "5";
            8'h36: to_ascii = "6";
            8'h3D: to_ascii = "7";
            8'h3E: to_ascii = "8";
            8'h46: to_ascii = "9";
            8'h29: to_ascii = " ";
            // Enter gives carriage return
            8'h5A: to_ascii = 8'h0D;
            default: to_ascii = 8'h00;
        endcase
    endfunction

    // Both lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Keyboard changes data on rising edge, so sample on falling
    assign clk_fall = clk_prev && !clk_sync[1];

    // Frame sequencer
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_count   <= 4'd0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (clk_fall) begin
                if (bit_count == 4'd0) begin
                    // Wait for start bit
                    if (!dat_sync[1]) begin
                        bit_count <= 4'd1;
                    end
                end else if (bit_count == 4'd10) begin
                    bit_count <= 4'd0;
                    // Stop must be 1, data plus parity must have odd weight
                    if (dat_sync[1] && (^frame_shift)) begin
                        frame_valid <= 1'b1;
                    end
                end else begin
                    bit_count <= bit_count + 4'd1;
                end
            end
        end
    end

    // Shift in data and parity, held until the next frame starts
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && bit_count != 4'd0 && bit_count != 4'd10) begin
            frame_shift <= {dat_sync[1], frame_shift[8:1]};
        end
    end

    // Make/break tracking and output pulses
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            scan_code    <= 8'h00;
            ascii_code   <= 8'h00;
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
            break_flag   <= 1'b0;
        end else begin
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
            if (frame_valid) begin
                if (frame_shift[7:0] == ps2_break_code) begin
                    // Next code is a release
                    break_flag <= 1'b1;
                end else begin
                    scan_code <= frame_shift[7:0];
                    if (break_flag) begin
                        key_released <= 1'b1;
                        break_flag   <= 1'b0;
                    end else begin
                        key_pressed <= 1'b1;
                        ascii_code  <= to_ascii(frame_shift[7:0]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/clock_slower.sv
`timescale 1ns/1ps
`default_nettype none

module clock_slower #(
    parameter int tick_divide = soc_pkg::tick_divide_default
) (
    input  wire  CLOCK_50,
    input  wire  KEY0,
    output logic cpu_tick
);

    // Wide enough to hold tick_divide - 1, at least one bit
    logic [$clog2(tick_divide + 1)-1:0] count;

    // Free-running count, enable pulse on the last clock of each period
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            count    <= '0;
            cpu_tick <= 1'b0;
        end else if (count == ($bits(count))'(tick_divide - 1)) begin
            // Wrap and fire the step enable
            count    <= '0;
            cpu_tick <= 1'b1;
        end else begin
            count    <= count + 1'b1;
            cpu_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Core-side bus widths
    localparam int addr_width = 64;
    localparam int data_width = 64;

    // Memory word and instruction width
    localparam int word_width = 32;

    // 12 KB of block RAM shared by ROM and RAM
    localparam int mem_words = 3072;
    // Word index bits, enough to span mem_words
    localparam int mem_index_width = $clog2(mem_words);

    // Boot ROM, read-only from the bus
    localparam logic [addr_width-1:0] rom_base = 64'h0000_0000_0000_0000;
    localparam logic [addr_width-1:0] rom_size = 64'h0000_0000_0000_1000;

    // Data RAM directly above the ROM
    localparam logic [addr_width-1:0] ram_base = 64'h0000_0000_0000_1000;
    localparam logic [addr_width-1:0] ram_size = 64'h0000_0000_0000_2000;

    // Keyboard ASCII register
    localparam logic [addr_width-1:0] key_base = 64'h0000_0000_0000_4000;

    // UART transmit register
    localparam logic [addr_width-1:0] art_base = 64'h0000_0000_0000_4008;

    // Vector presented to the core on a key press
    localparam logic [3:0] irq_keyboard = 4'd1;

    // One CPU step per second at 50 MHz
    localparam int tick_divide_default = 50_000_000;

    // PS/2 set-2 break prefix
    localparam logic [7:0] ps2_break_code = 8'hF0;

endpackage

`default_nettype wire
